/* common/mips_sys_pkg.sv */
// MIPS peripheral shared definitions
package mips_sys_pkg;

    localparam int NUM_TIMERS = 2;
    localparam int TC_IDX_W   = (NUM_TIMERS > 1) ? $clog2(NUM_TIMERS) : 1;

    typedef logic [31:0]         word_t;
    typedef logic [31:0]         addr_t;
    typedef logic [3:0]          byteen_t;
    typedef logic [7:0]          irq_vec_t;
    typedef logic [TC_IDX_W-1:0] tc_idx_t;

    // address map
    localparam addr_t DM_LAST      = 32'h0000_2FFF;
    localparam addr_t TC_BASE      = 32'h0000_7F00;
    localparam addr_t TC_STRIDE    = 32'h0000_0010;
    localparam addr_t TC_LAST      = TC_BASE + NUM_TIMERS * TC_STRIDE - 1;
    localparam addr_t INT_ACK_ADDR = 32'h0000_7F20;    // write only

    // byte offsets inside one timer
    localparam logic [3:0] TC_CTRL   = 4'h0;
    localparam logic [3:0] TC_PRESET = 4'h4;
    localparam logic [3:0] TC_COUNT  = 4'h8;            // read only

    // control register fields
    localparam int CTRL_EN   = 0;
    localparam int CTRL_MODE = 1;                       // two bits wide
    localparam int CTRL_IM   = 3;

    localparam logic [1:0] MODE_RELOAD = 2'd1;          // 0 is one-shot

    // hardware interrupt vector layout
    localparam int IRQ_BIT_TC0 = 2;
    localparam int IRQ_BIT_EXT = 4;

    typedef enum logic {
        IDLE,
        DONE
    } bridge_state_t;

    typedef enum logic [1:0] {
        TC_IDLE,
        TC_LOAD,
        TC_CNT,
        TC_INT
    } tc_state_t;

endpackage

/* src/bus_bridge.sv */
// CPU data bus bridge
`timescale 1ns/1ns

module bus_bridge
    import mips_sys_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  addr_t                 addr,
    input  word_t                 wdata,
    input  byteen_t               byteen,
    input  word_t                 dm_rdata,
    input  word_t                 tc_rdata,
    output logic                  ack,
    output word_t                 rdata,
    output logic                  exc,
    output addr_t                 dm_addr,
    output word_t                 dm_wdata,
    output byteen_t               dm_byteen,
    output logic [NUM_TIMERS-1:0] tc_sel,
    output logic                  tc_we,
    output logic [1:0]            tc_reg,
    output word_t                 tc_wdata,
    output logic                  int_ack
);

    bridge_state_t state;

    logic       start;
    logic       wr;
    logic       hit_dm;
    logic       hit_tc;
    logic       hit_ack;
    logic       reg_ok;
    logic       bad;
    logic       go;
    addr_t      tc_off;
    logic [3:0] reg_off;
    tc_idx_t    tc_idx;
    word_t      rd_mux;

    assign start = req && (state == IDLE);    // access happens in this cycle
    assign wr    = |byteen;                   // no byte lane means a read

    assign tc_off  = addr - TC_BASE;
    assign reg_off = {tc_off[3:2], 2'b00};
    assign tc_idx  = tc_idx_t'(tc_off / TC_STRIDE);

    assign reg_ok  = (reg_off == TC_CTRL) || (reg_off == TC_PRESET) || (reg_off == TC_COUNT);
    assign hit_dm  = (addr <= DM_LAST);
    assign hit_tc  = (addr >= TC_BASE) && (addr <= TC_LAST) && reg_ok;
    assign hit_ack = (addr == INT_ACK_ADDR);

    // unmapped, partial word to a register, or count write
    always_comb begin
        bad = 1'b0;
        if (!(hit_dm || hit_tc || hit_ack)) begin
            bad = 1'b1;
        end else if ((hit_tc || hit_ack) && wr && (byteen != 4'hF)) begin
            bad = 1'b1;
        end else if (hit_tc && wr && (reg_off == TC_COUNT)) begin
            bad = 1'b1;
        end
    end

    assign go = start && !bad;

    // data memory port
    assign dm_addr   = addr;
    assign dm_wdata  = wdata;
    assign dm_byteen = (go && hit_dm) ? byteen : '0;

    // timer strobes
    always_comb begin
        for (int i = 0; i < NUM_TIMERS; i++) begin
            tc_sel[i] = go && hit_tc && (tc_idx == tc_idx_t'(i));
        end
    end

    assign tc_we    = go && hit_tc && wr;
    assign tc_reg   = tc_off[3:2];
    assign tc_wdata = wdata;
    assign int_ack  = go && hit_ack && wr;

    // writes and faults return zero
    always_comb begin
        rd_mux = '0;
        if (!bad && !wr) begin
            if (hit_dm) begin
                rd_mux = dm_rdata;
            end else if (hit_tc) begin
                rd_mux = tc_rdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            rdata <= '0;
            exc   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= DONE;
                        rdata <= rd_mux;
                        exc   <= bad;
                    end
                end
                DONE: begin
                    if (!req) begin
                        state <= IDLE;    // ack drops at this edge
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign ack = (state == DONE);

endmodule

/* timer/timer_counter.sv */
// Timer/counter
`timescale 1ns/1ns

module timer_counter
    import mips_sys_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sel,
    input  logic       we,
    input  logic [1:0] reg_sel,
    input  word_t      wdata,
    output word_t      rdata,
    output logic       irq
);

    tc_state_t state;

    word_t ctrl;
    word_t preset;
    word_t count;
    logic  irq_flag;
    logic  wr_ctrl;
    logic  wr_preset;

    assign wr_ctrl   = sel && we && (reg_sel == TC_CTRL[3:2]);
    assign wr_preset = sel && we && (reg_sel == TC_PRESET[3:2]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl     <= '0;
            preset   <= '0;
            count    <= '0;
            irq_flag <= 1'b0;
            state    <= TC_IDLE;
        end else begin
            if (wr_preset) begin
                preset <= wdata;
            end
            if (wr_ctrl) begin
                ctrl     <= wdata;
                irq_flag <= 1'b0;
                state    <= TC_IDLE;    // restart from the new setting
            end else begin
                case (state)
                    TC_IDLE: begin
                        if (ctrl[CTRL_EN]) begin
                            state <= TC_LOAD;
                        end
                    end
                    TC_LOAD: begin
                        count <= preset;
                        state <= TC_CNT;
                    end
                    TC_CNT: begin
                        if (!ctrl[CTRL_EN]) begin
                            state <= TC_IDLE;
                        end else if (count <= 32'd1) begin
                            count    <= '0;    // zero preset stops at once
                            irq_flag <= 1'b1;
                            state    <= TC_INT;
                        end else begin
                            count <= count - 32'd1;
                        end
                    end
                    TC_INT: begin
                        if (ctrl[CTRL_MODE +: 2] == MODE_RELOAD) begin
                            irq_flag <= 1'b0;    // single cycle pulse
                            state    <= TC_LOAD;
                        end else begin
                            ctrl[CTRL_EN] <= 1'b0;    // flag held till next ctrl write
                            state         <= TC_IDLE;
                        end
                    end
                    default: state <= TC_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_sel)
            TC_CTRL[3:2]:   rdata = ctrl;
            TC_PRESET[3:2]: rdata = preset;
            TC_COUNT[3:2]:  rdata = count;
            default:        rdata = '0;
        endcase
    end

    assign irq = irq_flag && ctrl[CTRL_IM];

endmodule

/* src/irq_collect.sv */
// Interrupt collector
`timescale 1ns/1ns

module irq_collect
    import mips_sys_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_TIMERS-1:0] tc_sel,
    input  word_t                 tc_rdata_all [NUM_TIMERS],
    input  logic [NUM_TIMERS-1:0] tc_irq,
    input  logic                  ext_int,
    input  logic                  int_ack,
    output word_t                 tc_rdata,
    output irq_vec_t              hw_int
);

    logic [NUM_TIMERS-1:0] tc_irq_q;
    logic                  ext_s;
    logic                  ext_d;
    logic                  pending;

    // selects are one-hot or all low
    always_comb begin
        tc_rdata = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (tc_sel[i]) begin
                tc_rdata = tc_rdata | tc_rdata_all[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tc_irq_q <= '0;
            ext_s    <= 1'b0;
            ext_d    <= 1'b0;
            pending  <= 1'b0;
        end else begin
            tc_irq_q <= tc_irq;
            ext_s    <= ext_int;
            ext_d    <= ext_s;
            if (ext_s && !ext_d) begin
                pending <= 1'b1;    // new edge wins over ack
            end else if (int_ack) begin
                pending <= 1'b0;
            end
        end
    end

    always_comb begin
        hw_int = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            hw_int[IRQ_BIT_TC0 + i] = tc_irq_q[i];
        end
        hw_int[IRQ_BIT_EXT] = pending;
    end

endmodule

/* src/mips_periph.sv */
// MIPS peripheral subsystem top
`timescale 1ns/1ns

module mips_periph
    import mips_sys_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  addr_t    addr,
    input  word_t    wdata,
    input  byteen_t  byteen,
    input  logic     ext_int,
    input  word_t    dm_rdata,
    output logic     ack,
    output word_t    rdata,
    output logic     exc,
    output addr_t    dm_addr,
    output word_t    dm_wdata,
    output byteen_t  dm_byteen,
    output irq_vec_t hw_int
);

    logic [NUM_TIMERS-1:0] tc_sel;
    logic                  tc_we;
    logic [1:0]            tc_reg;
    word_t                 tc_wdata;
    word_t                 tc_rdata;
    word_t                 tc_rdata_all [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] tc_irq;
    logic                  int_ack;

    bus_bridge u_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .addr      (addr),
        .wdata     (wdata),
        .byteen    (byteen),
        .dm_rdata  (dm_rdata),
        .tc_rdata  (tc_rdata),
        .ack       (ack),
        .rdata     (rdata),
        .exc       (exc),
        .dm_addr   (dm_addr),
        .dm_wdata  (dm_wdata),
        .dm_byteen (dm_byteen),
        .tc_sel    (tc_sel),
        .tc_we     (tc_we),
        .tc_reg    (tc_reg),
        .tc_wdata  (tc_wdata),
        .int_ack   (int_ack)
    );

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_tc
        timer_counter u_tc (
            .clk     (clk),
            .rst_n   (rst_n),
            .sel     (tc_sel[i]),
            .we      (tc_we),
            .reg_sel (tc_reg),
            .wdata   (tc_wdata),
            .rdata   (tc_rdata_all[i]),
            .irq     (tc_irq[i])
        );
    end

    irq_collect u_irq (
        .clk          (clk),
        .rst_n        (rst_n),
        .tc_sel       (tc_sel),
        .tc_rdata_all (tc_rdata_all),
        .tc_irq       (tc_irq),
        .ext_int      (ext_int),
        .int_ack      (int_ack),
        .tc_rdata     (tc_rdata),
        .hw_int       (hw_int)
    );

endmodule

/* tb/periph_checker.sv */
// Peripheral reference checker
`timescale 1ns/1ns

module periph_checker
    import mips_sys_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  addr_t    addr,
    input  word_t    wdata,
    input  byteen_t  byteen,
    input  logic     ext_int,
    input  word_t    dm_rdata,
    input  logic     ack,
    input  word_t    rdata,
    input  logic     exc,
    input  addr_t    dm_addr,
    input  word_t    dm_wdata,
    input  byteen_t  dm_byteen,
    input  irq_vec_t hw_int,
    output int       errors,
    output int       checks
);

    word_t    mem [0:3071];
    byteen_t  vld [0:3071];    // bytes the model knows
    word_t    ctrl_m [NUM_TIMERS];
    word_t    pre_m [NUM_TIMERS];
    word_t    cnt_last [NUM_TIMERS];
    int       p_arm [NUM_TIMERS];
    int       t0 [NUM_TIMERS];
    int       last_rise [NUM_TIMERS];
    logic     armed [NUM_TIMERS];
    logic     rose [NUM_TIMERS];
    logic     ack_m;
    logic     rd_pend;
    logic     exc_e;
    logic     pend;
    logic     ext_s;
    logic     ext_d;
    word_t    rd_e;
    word_t    rd_mask;
    int       cnt_idx;
    irq_vec_t hw_q;
    irq_vec_t tmask;
    int       cyc;

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR at cycle %0d: %s", cyc, msg);
    endtask

    // one-shot timer has cleared its enable bit
    function automatic logic shot_done(input int k);
        return ctrl_m[k][CTRL_EN] && (ctrl_m[k][CTRL_MODE +: 2] != MODE_RELOAD)
            && (p_arm[k] != 0) && (cyc - 1 >= t0[k] + p_arm[k] + 3);
    endfunction

    task automatic model_access(output logic ack_wr);
        logic       wr;
        logic       bad;
        logic       is_tc;
        logic [1:0] r;
        int         k;
        int         w;
        wr      = (byteen != 4'h0);
        is_tc   = (addr >= TC_BASE) && (addr < TC_BASE + NUM_TIMERS * TC_STRIDE)
            && (addr[3:2] != 2'd3);
        r       = addr[3:2];
        k       = int'((addr - TC_BASE) >> 4);
        w       = int'(addr[13:2]);
        bad     = !((addr <= DM_LAST) || is_tc || (addr == INT_ACK_ADDR));
        ack_wr  = 1'b0;
        cnt_idx = -1;
        if ((is_tc || addr == INT_ACK_ADDR) && wr && byteen != 4'hF) begin
            bad = 1'b1;
        end
        if (is_tc && wr && r == 2'd2) begin
            bad = 1'b1;    // count is read only
        end
        rd_e    = '0;
        rd_mask = '1;
        exc_e   = bad;
        check_value("dm_byteen", word_t'(dm_byteen),
            word_t'((!bad && wr && addr <= DM_LAST) ? byteen : 4'h0));
        if (bad) begin
            return;
        end
        if (addr <= DM_LAST) begin
            check_value("dm_addr", dm_addr, addr);
            if (wr) begin
                check_value("dm_wdata", dm_wdata, wdata);
            end
            for (int b = 0; b < 4; b++) begin
                if (byteen[b]) begin
                    mem[w][8*b +: 8] = wdata[8*b +: 8];
                    vld[w][b]        = 1'b1;
                end
                if (!wr) begin
                    rd_e[8*b +: 8] = vld[w][b] ? mem[w][8*b +: 8] : dm_rdata[8*b +: 8];
                end
            end
        end else if (is_tc) begin
            if (wr && r == 2'd0) begin
                ctrl_m[k]   = wdata;
                t0[k]       = cyc;
                rose[k]     = 1'b0;
                p_arm[k]    = int'(pre_m[k]);
                cnt_last[k] = pre_m[k];
                armed[k]    = wdata[CTRL_EN] && wdata[CTRL_IM] && (pre_m[k] != 0);
            end else if (wr) begin
                pre_m[k] = wdata;
            end else if (r == 2'd0) begin
                rd_e = ctrl_m[k];
                if (shot_done(k)) begin
                    rd_e[CTRL_EN] = 1'b0;
                end
            end else if (r == 2'd1) begin
                rd_e = pre_m[k];
            end else begin
                rd_mask = '0;    // counting value judged on its own
                if (ctrl_m[k][CTRL_EN] && ctrl_m[k][CTRL_MODE +: 2] != MODE_RELOAD
                    && p_arm[k] != 0 && cyc - 1 >= t0[k] + 2) begin
                    cnt_idx = k;
                end
            end
        end else if (wr) begin
            ack_wr = 1'b1;
        end
    endtask

    task automatic watch_timer(input int k, input logic b);
        logic pb;
        logic reload;
        int   p;
        pb     = hw_q[IRQ_BIT_TC0 + k];
        reload = (ctrl_m[k][CTRL_MODE +: 2] == MODE_RELOAD);
        p      = p_arm[k];
        if (b && !pb) begin
            if (!armed[k]) begin
                flag_error($sformatf("timer %0d irq rose while masked or disabled", k));
            end else if (!rose[k] && (cyc - 1 - t0[k] < p || cyc - 1 - t0[k] > p + 3)) begin
                flag_error($sformatf("timer %0d first irq after %0d cycles, preset %0d",
                    k, cyc - 1 - t0[k], p));
            end else if (rose[k] && !reload) begin
                flag_error($sformatf("one-shot timer %0d fired twice", k));
            end else if (rose[k] && cyc - last_rise[k] != p + 2) begin
                flag_error($sformatf("timer %0d irq spacing %0d, preset %0d",
                    k, cyc - last_rise[k], p));
            end
            rose[k]      = 1'b1;
            last_rise[k] = cyc;
        end else if (!b && pb && armed[k] && rose[k] && !reload) begin
            flag_error($sformatf("one-shot timer %0d irq dropped without a ctrl write", k));
        end else if (b && pb && armed[k] && reload) begin
            flag_error($sformatf("auto-reload timer %0d irq longer than one cycle", k));
        end else if (!b && armed[k] && (rose[k] ? (reload && cyc - last_rise[k] > p + 2)
                                                : (cyc - 1 - t0[k] > p + 3))) begin
            flag_error($sformatf("timer %0d irq missing", k));
            armed[k] = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        logic ack_wr;
        irq_vec_t e;
        cyc++;
        if (!rst_n) begin
            errors  = 0;
            checks  = 0;
            cyc     = 0;
            ack_m   = 1'b0;
            rd_pend = 1'b0;
            pend    = 1'b0;
            ext_s   = 1'b0;
            ext_d   = 1'b0;
            hw_q    = '0;
            tmask   = '0;
            for (int i = 0; i < 3072; i++) begin
                vld[i] = 4'h0;
            end
            for (int i = 0; i < NUM_TIMERS; i++) begin
                ctrl_m[i]            = '0;
                pre_m[i]             = '0;
                p_arm[i]             = 0;
                armed[i]             = 1'b0;
                rose[i]              = 1'b0;
                tmask[IRQ_BIT_TC0+i] = 1'b1;
            end
        end else begin
            check_value("ack", word_t'(ack), word_t'(ack_m));
            e              = '0;
            e[IRQ_BIT_EXT] = pend;
            check_value("hw_int", word_t'(hw_int & ~tmask), word_t'(e));
            for (int i = 0; i < NUM_TIMERS; i++) begin
                watch_timer(i, hw_int[IRQ_BIT_TC0 + i]);
            end
            hw_q = hw_int;
            if (rd_pend) begin
                rd_pend = 1'b0;
                check_value("exc", word_t'(exc), word_t'(exc_e));
                check_value("rdata", rdata & rd_mask, rd_e & rd_mask);
                if (cnt_idx >= 0) begin
                    checks++;
                    if (rdata > cnt_last[cnt_idx]) begin
                        errors++;
                        $display("FAILED rdata: count %h, expected at most %h",
                            rdata, cnt_last[cnt_idx]);
                    end
                    cnt_last[cnt_idx] = rdata;    // count only goes down
                end
            end
            ack_wr = 1'b0;
            if (req && !ack_m) begin
                model_access(ack_wr);
                rd_pend = 1'b1;
            end else begin
                check_value("dm_byteen", word_t'(dm_byteen), '0);
            end
            if (ext_s && !ext_d) begin
                pend = 1'b1;
            end else if (ack_wr) begin
                pend = 1'b0;
            end
            ext_d = ext_s;
            ext_s = ext_int;
            ack_m = req;    // ack follows req one cycle late
        end
    end

endmodule

/* tb/tb_top.sv */
// Peripheral testbench top
`timescale 1ns/1ns

module tb_top;
    import mips_sys_pkg::*;

    localparam int ACK_TIMEOUT = 40;
    localparam int IRQ_TIMEOUT = 400;

    logic     clk;
    logic     rst_n;
    logic     req;
    addr_t    addr;
    word_t    wdata;
    byteen_t  byteen;
    logic     ext_int;
    word_t    dm_rdata;
    logic     ack;
    word_t    rdata;
    logic     exc;
    addr_t    dm_addr;
    word_t    dm_wdata;
    byteen_t  dm_byteen;
    irq_vec_t hw_int;
    int       errors;
    int       checks;
    int       timeouts;
    int       seed = 32'h5e3c715e;
    int       ext_seed;
    int       p;
    int       k;
    addr_t    a;
    byteen_t  be;
    word_t    dmem [0:3071];

    mips_periph uut (.*);

    periph_checker chk (.*);

    // behavioral data memory
    assign dm_rdata = (dm_addr <= DM_LAST) ? dmem[dm_addr[13:2]] : '0;

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dm_byteen[b]) begin
                dmem[dm_addr[13:2]][8*b +: 8] = dm_wdata[8*b +: 8];
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic addr_t tc_addr(input int idx, input logic [3:0] off);
        return TC_BASE + idx * TC_STRIDE + addr_t'(off);
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic give_up(input string msg);
        timeouts++;
        $display("ERROR: timeout, %s", msg);
        finish_run();
    endtask

    task automatic bus_access(input addr_t ad, input word_t d, input byteen_t bytes);
        int n;
        int hold;
        hold = $unsigned($random(seed)) % 4;    // slow cpu holds req
        @(negedge clk);
        req    = 1'b1;
        addr   = ad;
        wdata  = d;
        byteen = bytes;
        n      = 0;
        while (!ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            give_up("no ack for the bus request");
        end
        repeat (hold) @(negedge clk);
        req = 1'b0;
        n   = 0;
        while (ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            give_up("ack stayed high after the request dropped");
        end
    endtask

    task automatic wait_irq(input int bit_idx, input logic level);
        int n;
        n = 0;
        while (hw_int[bit_idx] !== level && n < IRQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (hw_int[bit_idx] !== level) begin
            give_up($sformatf("hw_int bit %0d never reached %0d", bit_idx, level));
        end
    endtask

    initial begin
        ext_seed = seed ^ 32'h0000_ffff;
        ext_int  = 1'b0;
        forever begin
            @(negedge clk);
            if ($unsigned($random(ext_seed)) % 23 == 0) begin
                ext_int = ~ext_int;
            end
        end
    end

    initial begin
        req      = 1'b0;
        addr     = '0;
        wdata    = '0;
        byteen   = 4'h0;
        rst_n    = 1'b0;
        timeouts = 0;
        for (int i = 0; i < 3072; i++) begin
            dmem[i] = (i * 32'h9e37_79b1) ^ {i[15:0], ~i[15:0]};
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (60) begin
            a  = ($unsigned($random(seed)) % 64) << 2;
            be = ($random(seed) & 1) ? 4'hF : (4'h1 << ($unsigned($random(seed)) % 4));
            bus_access(a, $random(seed), be);
            bus_access(($unsigned($random(seed)) % 64) << 2, '0, 4'h0);
        end
        for (int i = 0; i < NUM_TIMERS; i++) begin
            bus_access(tc_addr(i, TC_PRESET), $random(seed), 4'hF);
            bus_access(tc_addr(i, TC_CTRL), 32'h8, 4'hF);    // masked in, not enabled
            bus_access(tc_addr(i, TC_PRESET), '0, 4'h0);
            bus_access(tc_addr(i, TC_CTRL), '0, 4'h0);
        end
        repeat (6) begin
            k = $unsigned($random(seed)) % NUM_TIMERS;
            p = 1 + $unsigned($random(seed)) % 12;
            bus_access(tc_addr(k, TC_PRESET), p, 4'hF);
            bus_access(tc_addr(k, TC_CTRL), 32'h9, 4'hF);    // one-shot, irq unmasked
            repeat (3) bus_access(tc_addr(k, TC_COUNT), '0, 4'h0);
            wait_irq(IRQ_BIT_TC0 + k, 1'b1);
            bus_access(tc_addr(k, TC_CTRL), '0, 4'h0);
            bus_access(tc_addr(k, TC_CTRL), '0, 4'hF);
            bus_access(tc_addr(k, TC_CTRL), 32'h1, 4'hF);    // irq masked
            repeat (p + 8) @(negedge clk);
            bus_access(tc_addr(k, TC_CTRL), '0, 4'hF);
        end
        k = $unsigned($random(seed)) % NUM_TIMERS;
        p = 2 + $unsigned($random(seed)) % 8;
        bus_access(tc_addr(k, TC_PRESET), p, 4'hF);
        bus_access(tc_addr(k, TC_CTRL), 32'hB, 4'hF);    // auto-reload
        repeat (4) begin
            wait_irq(IRQ_BIT_TC0 + k, 1'b1);
            wait_irq(IRQ_BIT_TC0 + k, 1'b0);
        end
        bus_access(tc_addr(k, TC_CTRL), '0, 4'hF);
        bus_access(32'h0000_4000, $random(seed), 4'hF);
        bus_access(32'h0000_7F0C, '0, 4'h0);
        bus_access(32'h0000_7F40, 32'h1, 4'hF);
        bus_access(tc_addr(0, TC_PRESET), 32'h55, 4'h1);
        bus_access(tc_addr(1, TC_COUNT), 32'h77, 4'hF);
        bus_access(INT_ACK_ADDR, '0, 4'h3);
        bus_access(tc_addr(0, TC_PRESET), '0, 4'h0);
        repeat (4) begin
            wait_irq(IRQ_BIT_EXT, 1'b1);
            bus_access(INT_ACK_ADDR, '0, 4'hF);
        end
        finish_run();
    end

endmodule

/* tb.f */
common/mips_sys_pkg.sv
src/bus_bridge.sv
timer/timer_counter.sv
src/irq_collect.sv
src/mips_periph.sv
tb/periph_checker.sv
tb/tb_top.sv

/* Makefile */
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
